//--- common/cache_pkg.sv
// cache geometry and array types
package cache_pkg;

  localparam int unsigned NUM_WAYS  = 4;
  localparam int unsigned INDEX_W   = 4;
  localparam int unsigned TAG_W     = 8;
  localparam int unsigned LINE_W    = 128;
  localparam int unsigned ADDR_W    = INDEX_W + TAG_W;
  localparam int unsigned NUM_SETS  = 1 << INDEX_W;
  localparam int unsigned WAY_IDX_W = $clog2(NUM_WAYS);

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [LINE_W-1:0] data;
    logic              valid;
    logic              dirty;
    logic              shared;
  } cache_line_t;

  // vldrty covers valid, dirty and shared, data covers tag and data
  typedef struct packed {
    logic [NUM_WAYS-1:0] vldrty;
    logic [NUM_WAYS-1:0] data;
  } cl_be_t;

  typedef struct packed {
    logic [NUM_WAYS-1:0] req;
    logic                we;
    logic [INDEX_W-1:0]  index;
    logic [TAG_W-1:0]    tag;
    cache_line_t         wdata;
    cl_be_t              be;
  } array_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [LINE_W-1:0] data;
    logic              dirty;
    logic              shared;
  } fill_req_t;

endpackage

//--- common/snoop_pkg.sv
// ACE snoop channel types
package snoop_pkg;

  import cache_pkg::*;

  localparam int unsigned CD_DATA_W = 64;

  // ACSNOOP encodings as on the ACE bus
  typedef enum logic [3:0] {
    READ_ONCE     = 4'b0000,
    READ_SHARED   = 4'b0001,
    READ_UNIQUE   = 4'b0111,
    CLEAN_INVALID = 4'b1001
  } acsnoop_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    acsnoop_t          snoop;
  } ac_chan_t;

  typedef struct packed {
    logic dataTransfer;
    logic error;
    logic passDirty;
    logic isShared;
  } crresp_t;

  typedef struct packed {
    logic [CD_DATA_W-1:0] data;
    logic                 last;
  } cd_chan_t;

  typedef struct packed {
    logic     ac_valid;
    ac_chan_t ac;
    logic     cr_ready;
    logic     cd_ready;
  } snoop_req_t;

  typedef struct packed {
    logic     ac_ready;
    logic     cr_valid;
    crresp_t  cr_resp;
    logic     cd_valid;
    cd_chan_t cd;
  } snoop_resp_t;

endpackage

//--- rtl/cache_array.sv
// tag, state and data storage
`timescale 1ns/10ps

module cache_array import cache_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  array_req_t                 req_i,
  input  logic                       gnt_i,
  output cache_line_t [NUM_WAYS-1:0] line_o,
  output logic        [NUM_WAYS-1:0] hit_way_o,
  output logic        [NUM_WAYS-1:0] dirty_way_o,
  output logic        [NUM_WAYS-1:0] shared_way_o
);

  logic [NUM_WAYS-1:0][NUM_SETS-1:0] valid_q;
  logic [TAG_W-1:0]  tag_mem    [NUM_WAYS][NUM_SETS];
  logic [LINE_W-1:0] data_mem   [NUM_WAYS][NUM_SETS];
  logic              dirty_mem  [NUM_WAYS][NUM_SETS];
  logic              shared_mem [NUM_WAYS][NUM_SETS];

  logic                       access;
  logic [NUM_WAYS-1:0]        wr_way;
  cache_line_t [NUM_WAYS-1:0] rd_line;
  cache_line_t [NUM_WAYS-1:0] line_q;
  logic [TAG_W-1:0]           tag_q;

  assign access = gnt_i && |req_i.req;
  assign wr_way = (access && req_i.we) ? req_i.req : '0;

  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      rd_line[w].tag    = tag_mem[w][req_i.index];
      rd_line[w].data   = data_mem[w][req_i.index];
      rd_line[w].valid  = valid_q[w][req_i.index];
      rd_line[w].dirty  = dirty_mem[w][req_i.index];
      rd_line[w].shared = shared_mem[w][req_i.index];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (wr_way[w] && req_i.be.vldrty[w]) begin
          valid_q[w][req_i.index] <= req_i.wdata.valid;
        end
      end
    end
  end

  // read happens before the write at the same edge
  always_ff @(posedge clk_i) begin
    if (access) begin
      tag_q  <= req_i.tag;
      line_q <= rd_line;
    end
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (wr_way[w] && req_i.be.vldrty[w]) begin
        dirty_mem[w][req_i.index]  <= req_i.wdata.dirty;
        shared_mem[w][req_i.index] <= req_i.wdata.shared;
      end
      if (wr_way[w] && req_i.be.data[w]) begin
        tag_mem[w][req_i.index]  <= req_i.wdata.tag;
        data_mem[w][req_i.index] <= req_i.wdata.data;
      end
    end
  end

  assign line_o = line_q;

  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_way_o[w]    = line_q[w].valid && (line_q[w].tag == tag_q);
      dirty_way_o[w]  = line_q[w].valid && line_q[w].dirty;
      shared_way_o[w] = line_q[w].valid && line_q[w].shared;
    end
  end

  // fill control keeps every tag in at most one way of a set
  a_hit_unique: assert property (@(posedge clk_i) disable iff (!rst_ni)
    access |=> $onehot0(hit_way_o))
    else $error("tag present in more than one way");

endmodule

//--- rtl/array_arbiter.sv
// array port arbiter
`timescale 1ns/10ps

module array_arbiter import cache_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  array_req_t snoop_req_i,
  input  array_req_t fill_req_i,
  output logic       snoop_gnt_o,
  output logic       fill_gnt_o,
  output logic       fill_owns_o,
  output array_req_t arr_req_o,
  output logic       arr_gnt_o
);

  typedef enum logic [1:0] {
    OWN_NONE,
    OWN_SNOOP,
    OWN_FILL
  } owner_t;

  owner_t owner_d, owner_q;
  logic   snoop_act;
  logic   fill_act;

  assign snoop_act = |snoop_req_i.req;
  assign fill_act  = |fill_req_i.req;

  // fill wins only as owner or when the snoop side is quiet
  assign fill_gnt_o  = fill_act && (owner_q == OWN_FILL || !snoop_act);
  assign snoop_gnt_o = snoop_act && (owner_q != OWN_FILL || !fill_act);
  assign fill_owns_o = (owner_q == OWN_FILL);
  assign arr_gnt_o   = snoop_gnt_o | fill_gnt_o;

  always_comb begin
    arr_req_o = '0;
    owner_d   = OWN_NONE;
    if (fill_gnt_o) begin
      arr_req_o = fill_req_i;
      owner_d   = OWN_FILL;
    end else if (snoop_gnt_o) begin
      arr_req_o = snoop_req_i;
      owner_d   = OWN_SNOOP;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      owner_q <= OWN_NONE;
    end else begin
      owner_q <= owner_d;
    end
  end

  a_gnt_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(snoop_gnt_o && fill_gnt_o))
    else $error("both clients granted");

endmodule

//--- rtl/line_fill_ctrl.sv
// line fill port
`timescale 1ns/10ps

module line_fill_ctrl import cache_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                fill_valid_i,
  input  fill_req_t           fill_req_i,
  output logic                fill_ready_o,
  output array_req_t          arr_req_o,
  input  logic                arr_gnt_i,
  input  logic [NUM_WAYS-1:0] hit_way_i
);

  typedef enum logic [1:0] {
    F_IDLE,
    F_EVAL,
    F_WRITE
  } fill_state_t;

  fill_state_t          state_d, state_q;
  logic [WAY_IDX_W-1:0] victim_q;
  logic [NUM_WAYS-1:0]  way_d, way_q;
  logic                 miss_d, miss_q;

  // fill payload is held by the sender until fill_ready_o
  always_comb begin
    state_d = state_q;
    way_d   = way_q;
    miss_d  = miss_q;
    fill_ready_o = 1'b0;

    arr_req_o              = '0;
    arr_req_o.index        = fill_req_i.addr[INDEX_W-1:0];
    arr_req_o.tag          = fill_req_i.addr[ADDR_W-1:INDEX_W];
    arr_req_o.wdata.tag    = fill_req_i.addr[ADDR_W-1:INDEX_W];
    arr_req_o.wdata.data   = fill_req_i.data;
    arr_req_o.wdata.valid  = 1'b1;
    arr_req_o.wdata.dirty  = fill_req_i.dirty;
    arr_req_o.wdata.shared = fill_req_i.shared;

    case (state_q)
      F_IDLE: begin
        if (fill_valid_i) begin
          arr_req_o.req = '1;
          if (arr_gnt_i) begin
            state_d = F_EVAL;
          end
        end
      end
      F_EVAL: begin
        arr_req_o.req = '1;
        miss_d  = ~|hit_way_i;
        way_d   = |hit_way_i ? hit_way_i : NUM_WAYS'(1) << victim_q;
        state_d = F_WRITE;
      end
      F_WRITE: begin
        arr_req_o.req       = way_q;
        arr_req_o.we        = 1'b1;
        arr_req_o.be.vldrty = way_q;
        arr_req_o.be.data   = way_q;
        if (arr_gnt_i) begin
          fill_ready_o = 1'b1;
          state_d = F_IDLE;
        end
      end
      default: state_d = F_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= F_IDLE;
      victim_q <= '0;
    end else begin
      state_q <= state_d;
      // advance victim only when it was used
      if (state_q == F_WRITE && arr_gnt_i && miss_q) begin
        victim_q <= victim_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    way_q  <= way_d;
    miss_q <= miss_d;
  end

  a_fill_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    arr_req_o.we |-> $onehot(arr_req_o.req))
    else $error("fill write mask not one-hot");

endmodule

//--- snoop_ctrl/snoop_cache_ctrl.sv
// snoop cache controller
`timescale 1ns/10ps

module snoop_cache_ctrl import cache_pkg::*; import snoop_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       bypass_i,
  input  snoop_req_t                 snoop_port_i,
  output snoop_resp_t                snoop_port_o,
  output array_req_t                 arr_req_o,
  input  logic                       arr_gnt_i,
  input  logic                       fill_owns_i,
  input  cache_line_t [NUM_WAYS-1:0] arr_line_i,
  input  logic        [NUM_WAYS-1:0] hit_way_i,
  input  logic        [NUM_WAYS-1:0] dirty_way_i,
  input  logic        [NUM_WAYS-1:0] shared_way_i,
  output logic                       invalidate_o,
  output logic        [ADDR_W-1:0]   invalidate_addr_o,
  output logic                       readshared_done_valid_o,
  output logic        [ADDR_W-1:0]   readshared_done_addr_o,
  output logic                       busy_o
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_WAIT_GNT,
    S_EVAL_FLAGS,
    S_UPDATE_SHARED,
    S_INVALIDATE,
    S_SEND_CR,
    S_SEND_CD
  } state_t;

  state_t              state_d, state_q;
  acsnoop_t            snoop_d, snoop_q;
  crresp_t             cr_resp_d, cr_resp_q;
  logic                beat_d, beat_q;
  logic [ADDR_W-1:0]   addr_d, addr_q;
  logic [NUM_WAYS-1:0] hit_d, hit_q;
  logic                dirty_d, dirty_q;
  logic [LINE_W-1:0]   line_d, line_q;
  logic [LINE_W-1:0]   hit_data;
  logic                hit_dirty;
  logic                hit_shared;

  // data of the hitting way
  always_comb begin
    hit_data = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (hit_way_i[w]) begin
        hit_data = arr_line_i[w].data;
      end
    end
  end

  assign hit_dirty  = |(hit_way_i & dirty_way_i);
  assign hit_shared = |(hit_way_i & shared_way_i);

  assign busy_o                 = (state_q != S_IDLE);
  assign invalidate_addr_o      = addr_q;
  assign readshared_done_addr_o = addr_q;

  always_comb begin
    state_d   = state_q;
    snoop_d   = snoop_q;
    cr_resp_d = cr_resp_q;
    beat_d    = beat_q;
    addr_d    = addr_q;
    hit_d     = hit_q;
    dirty_d   = dirty_q;
    line_d    = line_q;

    snoop_port_o            = '0;
    arr_req_o               = '0;
    arr_req_o.index         = addr_q[INDEX_W-1:0];
    arr_req_o.tag           = addr_q[ADDR_W-1:INDEX_W];
    invalidate_o            = 1'b0;
    readshared_done_valid_o = 1'b0;

    case (state_q)
      S_IDLE: begin
        snoop_port_o.ac_ready = 1'b1;
        cr_resp_d = '0;
        beat_d    = 1'b0;
        if (snoop_port_i.ac_valid) begin
          addr_d  = snoop_port_i.ac.addr;
          snoop_d = snoop_port_i.ac.snoop;
          if (bypass_i) begin
            state_d = S_SEND_CR;
          end else if (snoop_port_i.ac.snoop inside
                       {READ_ONCE, READ_SHARED, READ_UNIQUE, CLEAN_INVALID}) begin
            state_d = S_WAIT_GNT;
          end else begin
            cr_resp_d.error = 1'b1;
            state_d = S_SEND_CR;
          end
        end
      end

      S_WAIT_GNT: begin
        // stay off the array while a fill is in progress
        if (!fill_owns_i) begin
          arr_req_o.req = '1;
          if (arr_gnt_i) begin
            state_d = S_EVAL_FLAGS;
          end
        end
      end

      S_EVAL_FLAGS: begin
        // keep ownership until the state write is done
        arr_req_o.req = '1;
        hit_d   = hit_way_i;
        dirty_d = hit_dirty;
        line_d  = hit_data;
        state_d = S_SEND_CR;
        if (|hit_way_i) begin
          cr_resp_d.dataTransfer = 1'b1;
          case (snoop_q)
            READ_ONCE: begin
              cr_resp_d.isShared = hit_shared;
            end
            READ_SHARED: begin
              cr_resp_d.isShared = 1'b1;
              state_d = S_UPDATE_SHARED;
            end
            READ_UNIQUE: begin
              cr_resp_d.passDirty = hit_dirty;
              state_d = S_INVALIDATE;
            end
            default: begin
              // clean invalid only moves dirty data
              cr_resp_d.dataTransfer = hit_dirty;
              cr_resp_d.passDirty    = hit_dirty;
              state_d = S_INVALIDATE;
            end
          endcase
        end
      end

      S_UPDATE_SHARED: begin
        arr_req_o.req           = hit_q;
        arr_req_o.we            = 1'b1;
        arr_req_o.be.vldrty     = hit_q;
        arr_req_o.wdata.valid   = 1'b1;
        arr_req_o.wdata.dirty   = dirty_q;
        arr_req_o.wdata.shared  = 1'b1;
        if (arr_gnt_i) begin
          readshared_done_valid_o = 1'b1;
          state_d = S_SEND_CR;
        end
      end

      S_INVALIDATE: begin
        // wdata state bits stay zero
        arr_req_o.req       = hit_q;
        arr_req_o.we        = 1'b1;
        arr_req_o.be.vldrty = hit_q;
        if (arr_gnt_i) begin
          invalidate_o = 1'b1;
          state_d = S_SEND_CR;
        end
      end

      S_SEND_CR: begin
        snoop_port_o.cr_valid = 1'b1;
        snoop_port_o.cr_resp  = cr_resp_q;
        if (snoop_port_i.cr_ready) begin
          state_d = cr_resp_q.dataTransfer ? S_SEND_CD : S_IDLE;
        end
      end

      S_SEND_CD: begin
        snoop_port_o.cd_valid = 1'b1;
        snoop_port_o.cd.data  = beat_q ? line_q[LINE_W-1:CD_DATA_W] : line_q[CD_DATA_W-1:0];
        snoop_port_o.cd.last  = beat_q;
        if (snoop_port_i.cd_ready) begin
          beat_d = ~beat_q;
          if (beat_q) begin
            state_d = S_IDLE;
          end
        end
      end

      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= S_IDLE;
      snoop_q   <= READ_ONCE;
      cr_resp_q <= '0;
      beat_q    <= 1'b0;
    end else begin
      state_q   <= state_d;
      snoop_q   <= snoop_d;
      cr_resp_q <= cr_resp_d;
      beat_q    <= beat_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q  <= addr_d;
    hit_q   <= hit_d;
    dirty_q <= dirty_d;
    line_q  <= line_d;
  end

  a_cr_cd_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(snoop_port_o.cr_valid && snoop_port_o.cd_valid))
    else $error("cr_valid and cd_valid high together");

  // relies on the fill side never placing one tag in two ways
  a_write_one_way: assert property (@(posedge clk_i) disable iff (!rst_ni)
    arr_req_o.we |-> $onehot(arr_req_o.req))
    else $error("snoop write hits more than one way");

endmodule

//--- rtl/coherent_dcache_top.sv
// coherent data cache slice
`timescale 1ns/10ps

module coherent_dcache_top import cache_pkg::*; import snoop_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              bypass_i,
  input  snoop_req_t        snoop_port_i,
  output snoop_resp_t       snoop_port_o,
  input  logic              fill_valid_i,
  input  fill_req_t         fill_req_i,
  output logic              fill_ready_o,
  output logic              invalidate_o,
  output logic [ADDR_W-1:0] invalidate_addr_o,
  output logic              readshared_done_valid_o,
  output logic [ADDR_W-1:0] readshared_done_addr_o,
  output logic              busy_o
);

  array_req_t                 snoop_req;
  array_req_t                 fill_req;
  array_req_t                 arr_req;
  logic                       snoop_gnt;
  logic                       fill_gnt;
  logic                       fill_owns;
  logic                       arr_gnt;
  cache_line_t [NUM_WAYS-1:0] arr_line;
  logic        [NUM_WAYS-1:0] hit_way;
  logic        [NUM_WAYS-1:0] dirty_way;
  logic        [NUM_WAYS-1:0] shared_way;

  snoop_cache_ctrl snoop_cache_ctrl_inst (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .bypass_i                (bypass_i),
    .snoop_port_i            (snoop_port_i),
    .snoop_port_o            (snoop_port_o),
    .arr_req_o               (snoop_req),
    .arr_gnt_i               (snoop_gnt),
    .fill_owns_i             (fill_owns),
    .arr_line_i              (arr_line),
    .hit_way_i               (hit_way),
    .dirty_way_i             (dirty_way),
    .shared_way_i            (shared_way),
    .invalidate_o            (invalidate_o),
    .invalidate_addr_o       (invalidate_addr_o),
    .readshared_done_valid_o (readshared_done_valid_o),
    .readshared_done_addr_o  (readshared_done_addr_o),
    .busy_o                  (busy_o)
  );

  line_fill_ctrl line_fill_ctrl_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .fill_valid_i (fill_valid_i),
    .fill_req_i   (fill_req_i),
    .fill_ready_o (fill_ready_o),
    .arr_req_o    (fill_req),
    .arr_gnt_i    (fill_gnt),
    .hit_way_i    (hit_way)
  );

  array_arbiter array_arbiter_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .snoop_req_i (snoop_req),
    .fill_req_i  (fill_req),
    .snoop_gnt_o (snoop_gnt),
    .fill_gnt_o  (fill_gnt),
    .fill_owns_o (fill_owns),
    .arr_req_o   (arr_req),
    .arr_gnt_o   (arr_gnt)
  );

  cache_array cache_array_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (arr_req),
    .gnt_i        (arr_gnt),
    .line_o       (arr_line),
    .hit_way_o    (hit_way),
    .dirty_way_o  (dirty_way),
    .shared_way_o (shared_way)
  );

endmodule

//--- tb/tb_coherent_dcache.sv
// coherent dcache testbench
`timescale 1ns/10ps

module tb_coherent_dcache
  import cache_pkg::*;
  import snoop_pkg::*;
();

  localparam logic [31:0] LFSR_SEED   = 32'hb8fd_a15c;
  localparam int          NUM_TXN     = 65;
  localparam int          CYCLE_LIMIT = 40 * NUM_TXN;

  logic        clk_i      = 1'b0;
  logic        rst_ni     = 1'b0;
  logic        bypass     = 1'b0;
  logic        ac_valid   = 1'b0;
  ac_chan_t    ac         = '0;
  logic        cr_ready   = 1'b1;
  logic        cd_ready   = 1'b1;
  logic        fill_valid = 1'b0;
  fill_req_t   fill_req   = '0;
  logic        bp_en      = 1'b0;
  logic [31:0] data_lfsr  = LFSR_SEED;
  logic [31:0] bp_lfsr    = LFSR_SEED;
  int          cycle_cnt  = 0;

  snoop_req_t        snoop_req;
  snoop_resp_t       snoop_resp;
  logic              fill_ready;
  logic              invalidate;
  logic [ADDR_W-1:0] invalidate_addr;
  logic              rs_valid;
  logic [ADDR_W-1:0] rs_addr;
  logic              busy;

  // reference line state, one live tag per set
  logic              ref_valid  [NUM_SETS];
  logic              ref_dirty  [NUM_SETS];
  logic              ref_shared [NUM_SETS];
  logic [LINE_W-1:0] ref_data   [NUM_SETS];

  crresp_t           exp_resp        = '0;
  logic [LINE_W-1:0] exp_line        = '0;
  logic [ADDR_W-1:0] exp_addr        = '0;
  logic              exp_inval       = 1'b0;
  logic              exp_rs          = 1'b0;
  int                exp_inval_total = 0;
  int                exp_rs_total    = 0;
  logic [63:0]       exp_beat;

  logic     beat_q;
  int       inval_cnt;
  int       rs_cnt;
  logic     prev_cr_valid;
  logic     prev_cr_ready;
  crresp_t  prev_cr_resp;
  logic     prev_cd_valid;
  logic     prev_cd_ready;
  cd_chan_t prev_cd;
  logic     snoop_open;

  assign snoop_req = {ac_valid, ac, cr_ready, cd_ready};
  assign exp_beat  = beat_q ? exp_line[LINE_W-1:64] : exp_line[63:0];

  coherent_dcache_top coherent_dcache_top_inst (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .bypass_i                (bypass),
    .snoop_port_i            (snoop_req),
    .snoop_port_o            (snoop_resp),
    .fill_valid_i            (fill_valid),
    .fill_req_i              (fill_req),
    .fill_ready_o            (fill_ready),
    .invalidate_o            (invalidate),
    .invalidate_addr_o       (invalidate_addr),
    .readshared_done_valid_o (rs_valid),
    .readshared_done_addr_o  (rs_addr),
    .busy_o                  (busy)
  );

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [TAG_W-1:0] tag_for(input int set);
    return 8'(set * 29 + 55);
  endfunction

  function automatic logic [3:0] pick_op(input logic [1:0] sel);
    case (sel)
      2'd0:    return READ_ONCE;
      2'd1:    return READ_SHARED;
      2'd2:    return READ_UNIQUE;
      default: return CLEAN_INVALID;
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [127:0] got,
                                 input logic [127:0] want);
    $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, name, got, want);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic draw_bits(input int n, output logic [LINE_W-1:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      data_lfsr = lfsr_next(data_lfsr);
      v = {v[LINE_W-2:0], data_lfsr[0]};
    end
  endtask

  // random ready only while back-pressure is on
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      report_error("run did not finish within its cycle limit");
    end
    if (bp_en) begin
      bp_lfsr = lfsr_next(bp_lfsr);
      cr_ready <= bp_lfsr[0];
      bp_lfsr = lfsr_next(bp_lfsr);
      cd_ready <= bp_lfsr[0];
    end else begin
      cr_ready <= 1'b1;
      cd_ready <= 1'b1;
    end
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_q        <= 1'b0;
      inval_cnt     <= 0;
      rs_cnt        <= 0;
      prev_cr_valid <= 1'b0;
      prev_cr_ready <= 1'b0;
      prev_cr_resp  <= '0;
      prev_cd_valid <= 1'b0;
      prev_cd_ready <= 1'b0;
      prev_cd       <= '0;
      snoop_open    <= 1'b0;
    end else begin
      if (snoop_resp.cd_valid && cd_ready) begin
        beat_q <= ~beat_q;
      end
      if (invalidate) begin
        inval_cnt <= inval_cnt + 1;
      end
      if (rs_valid) begin
        rs_cnt <= rs_cnt + 1;
      end
      // a snoop is open from its address handshake to its last handshake
      if (ac_valid && snoop_resp.ac_ready) begin
        snoop_open <= 1'b1;
      end else if ((snoop_resp.cr_valid && cr_ready && !snoop_resp.cr_resp.dataTransfer) ||
                   (snoop_resp.cd_valid && cd_ready && snoop_resp.cd.last)) begin
        snoop_open <= 1'b0;
      end
      prev_cr_valid <= snoop_resp.cr_valid;
      prev_cr_ready <= cr_ready;
      prev_cr_resp  <= snoop_resp.cr_resp;
      prev_cd_valid <= snoop_resp.cd_valid;
      prev_cd_ready <= cd_ready;
      prev_cd       <= snoop_resp.cd;
    end
  end

  a_cr_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    snoop_resp.cr_valid |-> snoop_resp.cr_resp == exp_resp)
    else report_mismatch("cr_resp", 128'(snoop_resp.cr_resp), 128'(exp_resp));

  a_cd_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    snoop_resp.cd_valid |-> snoop_resp.cd.data == exp_beat)
    else report_mismatch("cd.data", 128'(snoop_resp.cd.data), 128'(exp_beat));

  a_cd_last: assert property (@(posedge clk_i) disable iff (!rst_ni)
    snoop_resp.cd_valid |-> snoop_resp.cd.last == beat_q)
    else report_mismatch("cd.last", 128'(snoop_resp.cd.last), 128'(beat_q));

  a_cd_allowed: assert property (@(posedge clk_i) disable iff (!rst_ni)
    snoop_resp.cd_valid |-> exp_resp.dataTransfer)
    else report_error("data beat sent for a response without dataTransfer");

  // payload holds while valid waits for ready
  a_cr_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    prev_cr_valid && !prev_cr_ready |->
      snoop_resp.cr_valid && snoop_resp.cr_resp == prev_cr_resp)
    else report_mismatch("cr_resp held", 128'(snoop_resp.cr_resp), 128'(prev_cr_resp));

  a_cd_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    prev_cd_valid && !prev_cd_ready |-> snoop_resp.cd_valid && snoop_resp.cd == prev_cd)
    else report_mismatch("cd held", 128'(snoop_resp.cd), 128'(prev_cd));

  a_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy == snoop_open)
    else report_mismatch("busy_o", 128'(busy), 128'(snoop_open));

  a_inval_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
    invalidate |-> exp_inval)
    else report_error("invalidate pulse on a snoop that keeps the line");

  a_inval_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    invalidate |-> invalidate_addr == exp_addr)
    else report_mismatch("invalidate_addr_o", 128'(invalidate_addr), 128'(exp_addr));

  a_rs_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rs_valid |-> exp_rs)
    else report_error("readshared_done pulse without a READ_SHARED hit");

  a_rs_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rs_valid |-> rs_addr == exp_addr)
    else report_mismatch("readshared_done_addr_o", 128'(rs_addr), 128'(exp_addr));

  a_fill_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fill_ready |-> fill_valid)
    else report_error("fill_ready_o with no fill pending");

  task automatic do_fill(input int set, input logic dirty, input logic shared);
    fill_req_t         req;
    logic [LINE_W-1:0] line;
    draw_bits(LINE_W, line);
    req.addr   = {tag_for(set), 4'(set)};
    req.data   = line;
    req.dirty  = dirty;
    req.shared = shared;
    @(posedge clk_i);
    fill_valid <= 1'b1;
    fill_req   <= req;
    do begin
      @(posedge clk_i);
    end while (!fill_ready);
    fill_valid <= 1'b0;
    ref_valid[set]  = 1'b1;
    ref_dirty[set]  = dirty;
    ref_shared[set] = shared;
    ref_data[set]   = line;
  endtask

  task automatic do_snoop(input logic [3:0] op, input int set, input logic miss,
                          input logic byp);
    logic [ADDR_W-1:0] addr;
    crresp_t           resp;
    logic              hit;
    logic              done;
    @(posedge clk_i);
    addr      = {miss ? tag_for(set) ^ 8'hff : tag_for(set), 4'(set)};
    hit       = ref_valid[set] && !miss;
    resp      = '0;
    exp_inval = 1'b0;
    exp_rs    = 1'b0;
    if (byp) begin
      resp = '0;
    end else if (op != READ_ONCE && op != READ_SHARED && op != READ_UNIQUE &&
                 op != CLEAN_INVALID) begin
      resp.error = 1'b1;
    end else if (hit) begin
      resp.dataTransfer = 1'b1;
      case (op)
        READ_ONCE: resp.isShared = ref_shared[set];
        READ_SHARED: begin
          resp.isShared   = 1'b1;
          ref_shared[set] = 1'b1;
          exp_rs          = 1'b1;
        end
        READ_UNIQUE: begin
          resp.passDirty = ref_dirty[set];
          ref_valid[set] = 1'b0;
          exp_inval      = 1'b1;
        end
        default: begin
          resp.dataTransfer = ref_dirty[set];
          resp.passDirty    = ref_dirty[set];
          ref_valid[set]    = 1'b0;
          exp_inval         = 1'b1;
        end
      endcase
    end
    exp_resp        = resp;
    exp_line        = ref_data[set];
    exp_addr        = addr;
    exp_inval_total = exp_inval_total + (exp_inval ? 1 : 0);
    exp_rs_total    = exp_rs_total + (exp_rs ? 1 : 0);
    bypass   <= byp;
    ac_valid <= 1'b1;
    ac.addr  <= addr;
    ac.snoop <= acsnoop_t'(op);
    do begin
      @(posedge clk_i);
    end while (!snoop_resp.ac_ready);
    ac_valid <= 1'b0;
    bypass   <= 1'b0;
    // ends on the response without data or on the last beat
    done = 1'b0;
    while (!done) begin
      @(posedge clk_i);
      done = (snoop_resp.cr_valid && cr_ready && !snoop_resp.cr_resp.dataTransfer) ||
             (snoop_resp.cd_valid && cd_ready && snoop_resp.cd.last);
    end
    assert (inval_cnt == exp_inval_total)
      else report_mismatch("invalidate_o count", 128'(inval_cnt), 128'(exp_inval_total));
    assert (rs_cnt == exp_rs_total)
      else report_mismatch("readshared_done count", 128'(rs_cnt), 128'(exp_rs_total));
  endtask

  initial begin
    logic [LINE_W-1:0] rnd;
    for (int s = 0; s < NUM_SETS; s++) begin
      ref_valid[s]  = 1'b0;
      ref_dirty[s]  = 1'b0;
      ref_shared[s] = 1'b0;
      ref_data[s]   = '0;
    end
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    assert (snoop_resp.ac_ready) else report_error("ac_ready low after reset");
    assert (!snoop_resp.cr_valid && !snoop_resp.cd_valid)
      else report_error("snoop channel valid after reset");
    assert (!invalidate && !rs_valid && !fill_ready)
      else report_error("pulse output high after reset");

    // dirty and shared follow the set number
    for (int s = 0; s < NUM_SETS; s++) begin
      do_fill(s, s[0], s[1]);
    end
    do_snoop(READ_ONCE, 0, 1'b1, 1'b0);
    do_snoop(READ_SHARED, 1, 1'b1, 1'b0);
    for (int s = 0; s < 4; s++) begin
      do_snoop(READ_ONCE, s, 1'b0, 1'b0);
    end
    do_snoop(READ_SHARED, 4, 1'b0, 1'b0);
    do_snoop(READ_SHARED, 5, 1'b0, 1'b0);
    do_snoop(READ_ONCE, 4, 1'b0, 1'b0);
    do_snoop(READ_ONCE, 5, 1'b0, 1'b0);
    do_snoop(CLEAN_INVALID, 5, 1'b0, 1'b0);
    do_snoop(CLEAN_INVALID, 7, 1'b0, 1'b0);
    do_snoop(CLEAN_INVALID, 6, 1'b0, 1'b0);
    do_snoop(READ_UNIQUE, 8, 1'b0, 1'b0);
    do_snoop(READ_UNIQUE, 9, 1'b0, 1'b0);
    for (int s = 5; s < 10; s++) begin
      do_snoop(READ_ONCE, s, 1'b0, 1'b0);
    end
    do_snoop(READ_ONCE, 10, 1'b0, 1'b1);
    do_snoop(4'b0011, 10, 1'b0, 1'b0);
    do_snoop(READ_ONCE, 10, 1'b0, 1'b0);

    // fills race snoops on other sets
    @(posedge clk_i);
    bp_en <= 1'b1;
    for (int i = 0; i < 5; i++) begin
      draw_bits(4, rnd);
      fork
        do_fill(5 + i, rnd[0], rnd[1]);
        do_snoop(pick_op(rnd[3:2]), 10 + i, 1'b0, 1'b0);
      join
    end
    for (int s = 0; s < NUM_SETS; s++) begin
      draw_bits(2, rnd);
      do_snoop(pick_op(rnd[1:0]), s, 1'b0, 1'b0);
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- files.f
common/cache_pkg.sv
common/snoop_pkg.sv
rtl/cache_array.sv
rtl/array_arbiter.sv
rtl/line_fill_ctrl.sv
snoop_ctrl/snoop_cache_ctrl.sv
rtl/coherent_dcache_top.sv
tb/tb_coherent_dcache.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_coherent_dcache
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log for the pass message"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
